//--- bench/flane_stimulus.txt
# D addr rnw vma selmask | R addr pal_cs src | I pause irq_n | M ch0 ch1 snd peak
# B data cen addr rom_addr pcm_msb | C start coin joy1 joy2 service dipa dipb dipc reads
D 0000 1 1 08
D 0800 1 1 00
D 0c00 0 1 00
D 0d00 0 1 04
D 0e00 1 1 02
D 0f00 1 1 01
D 1800 1 1 10
D 1000 1 1 08
D 3456 1 1 08
D 4000 1 1 20
D 4000 0 0 00
D ffff 1 1 20
D c000 1 0 00
R 8000 0 0
R 8000 1 0
R 1900 0 1
R 2000 1 2
R 2000 0 3
R 0f00 0 4
R 0d00 0 5
R 0c00 0 5
C 2 1 2a 15 0 5a c3 6 f6 da e5 f1 5a c3
C 3 3 3f 3f 1 ff 00 0 f0 ff ff ff ff 00
C 1 2 0c 30 1 12 34 9 f9 f0 cc ee 12 34
B 1c 1 4123 14123 1
B 04 1 5abc 0dabc 0
B 18 0 5abc 0dabc 0
B 08 1 9234 01234 0
B 00 0 6000 12000 0
I 1 0
I 0 1
M 100 080 1200 0
M f00 010 f4c0 0
M 555 555 7ff8 0
M 556 555 7fff 1
M 7ff 7ff 7fff 1
M 800 800 8000 1
M aab aab 8008 0
M 000 000 0000 0

//--- flane_main.f
verilog/flane_map_pkg.sv
verilog/flane_snd_pkg.sv
verilog/flane_cab_inputs.sv
verilog/flane_bus_decode.sv
verilog/flane_snd_mixer.sv
verilog/flane_main.sv
bench/flane_main_assertions.sv
bench/flane_main_tb.sv

//--- Bender.yml
package:
  name: flane_main

sources:
  - verilog/flane_map_pkg.sv
  - verilog/flane_snd_pkg.sv
  - verilog/flane_cab_inputs.sv
  - verilog/flane_bus_decode.sv
  - verilog/flane_snd_mixer.sv
  - verilog/flane_main.sv
  - target: simulation
    files:
      - bench/flane_main_assertions.sv
      - bench/flane_main_tb.sv

//--- bench/flane_main_tb.sv
// testbench for the main board glue; runs every operation listed in the stimulus file
`default_nettype none

module flane_main_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int half_period = 20;

    logic                                   clk;
    logic                                   rst;
    logic                                   cpu_cen;
    logic                                   snd_cen;
    logic [flane_map_pkg::addr_w-1:0]       addr;
    logic                                   rnw;
    logic                                   vma;
    logic [flane_map_pkg::data_w-1:0]       cpu_dout;
    logic [flane_map_pkg::data_w-1:0]       cpu_din;
    logic                                   irq_ack;
    logic                                   irq_n;
    logic                                   rom_cs;
    logic                                   ram_cs;
    logic                                   gfx_cs;
    logic                                   pcm0_cs;
    logic                                   pcm1_cs;
    logic                                   prot_cs;
    logic [flane_map_pkg::rom_aw-1:0]       rom_addr;
    logic [flane_map_pkg::data_w-1:0]       rom_data;
    logic [flane_map_pkg::data_w-1:0]       ram_dout;
    logic [flane_map_pkg::data_w-1:0]       gfx_dout;
    logic [flane_map_pkg::data_w-1:0]       pal_dout;
    logic [flane_map_pkg::data_w-1:0]       prot_dout;
    logic                                   pal_cs;
    logic                                   gfx_irqn;
    logic [1:0]                             start_button;
    logic [1:0]                             coin_input;
    logic [5:0]                             joystick1;
    logic [5:0]                             joystick2;
    logic                                   service;
    logic                                   dip_pause;
    logic [7:0]                             dipsw_a;
    logic [7:0]                             dipsw_b;
    logic [3:0]                             dipsw_c;
    logic                                   pcm_msb;
    logic signed [flane_snd_pkg::pcm_w-1:0] ch0;
    logic signed [flane_snd_pkg::pcm_w-1:0] ch1;
    logic signed [flane_snd_pkg::snd_w-1:0] snd;
    logic                                   peak;

    int             fd;
    int             seed;
    int             stim_lines;
    int             test_num;
    int             test_errors;
    int             pass_count;
    int             fail_count;
    int             n;
    logic           done;
    byte            op;
    logic [2047:0]  line;

    // gains of 0.75 on both channels
    flane_main #(
        .GAIN0 (8'h0C),
        .GAIN1 (8'h0C)
    ) DUT (.*);

    always #half_period clk = ~clk;

    task automatic compare_hex(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("CHECK FAILED %s expected %h actual %h", name, expected, actual);
            test_errors++;
        end
    endtask

    task automatic report_malformed(input string what);
        $display("stimulus line for operation %s is missing fields or malformed", what);
        test_errors++;
    endtask

    task automatic finish_test(input string label);
        if (test_errors == 0) begin
            pass_count++;
            $display("test %0d (%s) passed", test_num, label);
        end else begin
            fail_count++;
            $display("test %0d (%s) failed with %0d errors", test_num, label, test_errors);
        end
        test_num++;
        test_errors = 0;
    endtask

    // selects are combinational, checked in the same cycle
    task automatic decode_selects();
        logic [15:0] a;
        logic        r;
        logic        v;
        logic [5:0]  mask;
        int          cnt;
        cnt = $fscanf(fd, "%h %h %h %h", a, r, v, mask);
        if (cnt != 4) begin
            report_malformed("D");
            return;
        end
        @(posedge clk);
        addr <= a;
        rnw  <= r;
        vma  <= v;
        @(negedge clk);
        compare_hex("rom_cs", mask[5], rom_cs);
        compare_hex("ram_cs", mask[4], ram_cs);
        compare_hex("gfx_cs", mask[3], gfx_cs);
        compare_hex("pcm0_cs", mask[2], pcm0_cs);
        compare_hex("pcm1_cs", mask[1], pcm1_cs);
        compare_hex("prot_cs", mask[0], prot_cs);
    endtask

    // source order rom, ram, pal, gfx, prot; index 5 means open bus
    task automatic read_source();
        logic [15:0] a;
        logic        pal;
        logic [3:0]  sel;
        logic [7:0]  src [5];
        logic [7:0]  expected;
        logic        clash;
        int          cnt;
        int          i;
        int          j;
        cnt = $fscanf(fd, "%h %h %h", a, pal, sel);
        if (cnt != 3) begin
            report_malformed("R");
            return;
        end
        // distinct values, none equal to open bus
        for (i = 0; i < 5; i++) begin
            clash = 1'b1;
            while (clash) begin
                src[i] = $random(seed);
                clash  = src[i] == flane_map_pkg::open_bus;
                for (j = 0; j < i; j++) begin
                    if (src[j] == src[i]) begin
                        clash = 1'b1;
                    end
                end
            end
        end
        expected = (sel < 5) ? src[sel] : flane_map_pkg::open_bus;
        @(posedge clk);
        addr      <= a;
        rnw       <= 1'b1;
        vma       <= 1'b1;
        pal_cs    <= pal;
        rom_data  <= src[0];
        ram_dout  <= src[1];
        pal_dout  <= src[2];
        gfx_dout  <= src[3];
        prot_dout <= src[4];
        @(posedge clk);
        pal_cs <= 1'b0;
        @(negedge clk);
        compare_hex("cpu_din", expected, cpu_din);
    endtask

    task automatic cabinet_bytes();
        logic [1:0]  st;
        logic [1:0]  cn;
        logic [5:0]  j1;
        logic [5:0]  j2;
        logic        sv;
        logic [7:0]  da;
        logic [7:0]  db;
        logic [3:0]  dc;
        logic [7:0]  expected [6];
        logic [15:0] rd_addr [6];
        int          cnt;
        int          i;
        cnt = $fscanf(fd, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                      st, cn, j1, j2, sv, da, db, dc, expected[0], expected[1],
                      expected[2], expected[3], expected[4], expected[5]);
        if (cnt != 14) begin
            report_malformed("C");
            return;
        end
        // four input bytes, then DIP bank a and b
        rd_addr = '{16'h0800, 16'h0801, 16'h0802, 16'h0803, 16'h0900, 16'h0901};
        @(posedge clk);
        start_button <= st;
        coin_input   <= cn;
        joystick1    <= j1;
        joystick2    <= j2;
        service      <= sv;
        dipsw_a      <= da;
        dipsw_b      <= db;
        dipsw_c      <= dc;
        addr         <= rd_addr[0];
        rnw          <= 1'b1;
        vma          <= 1'b1;
        // input register plus read register
        repeat (2) @(posedge clk);
        @(negedge clk);
        compare_hex($sformatf("cpu_din at %h", rd_addr[0]), expected[0], cpu_din);
        for (i = 1; i < 6; i++) begin
            @(posedge clk);
            addr <= rd_addr[i];
            @(posedge clk);
            @(negedge clk);
            compare_hex($sformatf("cpu_din at %h", rd_addr[i]), expected[i], cpu_din);
        end
    endtask

    task automatic bank_write();
        logic [7:0]  data;
        logic        cen;
        logic [15:0] a;
        logic [16:0] exp_addr;
        logic        exp_msb;
        int          cnt;
        cnt = $fscanf(fd, "%h %h %h %h %h", data, cen, a, exp_addr, exp_msb);
        if (cnt != 5) begin
            report_malformed("B");
            return;
        end
        @(posedge clk);
        addr     <= {4'h0, 1'b1, flane_map_pkg::io_bank, 8'h00};
        rnw      <= 1'b0;
        vma      <= 1'b1;
        cpu_dout <= data;
        cpu_cen  <= cen;
        @(posedge clk);
        addr    <= a;
        rnw     <= 1'b1;
        cpu_cen <= 1'b0;
        @(negedge clk);
        compare_hex("rom_addr", exp_addr, rom_addr);
        compare_hex("pcm_msb", exp_msb, pcm_msb);
    endtask

    task automatic irq_pulse();
        logic pause;
        logic exp_irq;
        int   cnt;
        cnt = $fscanf(fd, "%h %h", pause, exp_irq);
        if (cnt != 2) begin
            report_malformed("I");
            return;
        end
        @(posedge clk);
        dip_pause <= pause;
        gfx_irqn  <= 1'b1;
        irq_ack   <= 1'b0;
        @(posedge clk);
        gfx_irqn <= 1'b0;
        @(posedge clk);
        irq_ack <= 1'b1;
        @(negedge clk);
        compare_hex("irq_n", exp_irq, irq_n);
        @(posedge clk);
        irq_ack  <= 1'b0;
        gfx_irqn <= 1'b1;
        @(negedge clk);
        compare_hex("irq_n", 32'd1, irq_n);
    endtask

    task automatic mix_pair();
        logic [11:0] a0;
        logic [11:0] a1;
        logic [15:0] exp_snd;
        logic        exp_peak;
        int          cnt;
        cnt = $fscanf(fd, "%h %h %h %h", a0, a1, exp_snd, exp_peak);
        if (cnt != 4) begin
            report_malformed("M");
            return;
        end
        @(posedge clk);
        ch0     <= a0;
        ch1     <= a1;
        snd_cen <= 1'b1;
        @(posedge clk);
        snd_cen <= 1'b0;
        @(negedge clk);
        compare_hex("snd", exp_snd, {16'h0, snd});
        compare_hex("peak", exp_peak, peak);
    endtask

    // budget of eight clocks per stimulus line plus a fixed margin
    initial begin
        wait (stim_lines > 0);
        #((stim_lines * 8 + 100) * 40);
        $display("timeout: the stimulus did not finish in the expected time");
        $display("TEST FAIL");
        $finish;
    end

    initial begin
        clk          = 1'b0;
        rst          = 1'b1;
        cpu_cen      = 1'b0;
        snd_cen      = 1'b0;
        addr         = '0;
        rnw          = 1'b1;
        vma          = 1'b0;
        cpu_dout     = '0;
        irq_ack      = 1'b0;
        rom_data     = '0;
        ram_dout     = '0;
        gfx_dout     = '0;
        pal_dout     = '0;
        prot_dout    = '0;
        pal_cs       = 1'b0;
        gfx_irqn     = 1'b1;
        start_button = 2'b11;
        coin_input   = 2'b11;
        joystick1    = '1;
        joystick2    = '1;
        service      = 1'b1;
        dip_pause    = 1'b0;
        dipsw_a      = 8'hff;
        dipsw_b      = 8'hff;
        dipsw_c      = 4'hf;
        ch0          = '0;
        ch1          = '0;
        seed         = 32'hcd078fac;
        stim_lines   = 0;
        test_num     = 0;
        test_errors  = 0;
        pass_count   = 0;
        fail_count   = 0;
        done         = 1'b0;

        fd = $fopen("bench/flane_stimulus.txt", "r");
        if (fd == 0) begin
            $display("cannot open the stimulus file bench/flane_stimulus.txt");
            fail_count++;
        end else begin
            while ($fgets(line, fd) != 0) begin
                stim_lines++;
            end
            $fclose(fd);
            fd = $fopen("bench/flane_stimulus.txt", "r");
        end

        repeat (2) @(posedge clk);
        @(negedge clk);
        compare_hex("cpu_din", flane_map_pkg::open_bus, cpu_din);
        compare_hex("irq_n", 32'd1, irq_n);
        compare_hex("pcm_msb", 32'd0, pcm_msb);
        compare_hex("snd", 32'd0, {16'h0, snd});
        compare_hex("peak", 32'd0, peak);
        finish_test("reset");
        @(posedge clk);
        rst <= 1'b0;

        while (fd != 0 && !done) begin
            n = $fscanf(fd, " %c", op);
            if (n != 1) begin
                done = 1'b1;
            end else if (op == "#") begin
                n = $fgets(line, fd);
            end else begin
                case (op)
                    "D": decode_selects();
                    "R": read_source();
                    "C": cabinet_bytes();
                    "B": bank_write();
                    "I": irq_pulse();
                    "M": mix_pair();
                    default: begin
                        $display("unknown operation '%c' in the stimulus file", op);
                        test_errors++;
                        n = $fgets(line, fd);
                    end
                endcase
                finish_test($sformatf("op %c", op));
            end
        end
        if (fd != 0) begin
            $fclose(fd);
        end

        $display("tests passed %0d, failed %0d, assertion failures %0d",
                 pass_count, fail_count, DUT.u_decode.u_assertions.assert_errors);
        if (fail_count == 0 && DUT.u_decode.u_assertions.assert_errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- bench/flane_main_assertions.sv
// concurrent checks on the bus decoder, attached to every decoder instance with bind
`default_nettype none

module flane_main_assertions (
    input wire                              clk,
    input wire                              rst,
    input wire [flane_map_pkg::addr_w-1:0]  addr,
    input wire                              rom_cs,
    input wire                              ram_cs,
    input wire                              gfx_cs,
    input wire                              pcm0_cs,
    input wire                              pcm1_cs,
    input wire                              prot_cs,
    input wire                              irq_ack,
    input wire                              irq_n
);
    timeunit 1ns;
    timeprecision 1ps;

    int   assert_errors = 0;
    logic io_window;

    assign io_window = addr[15:12] == flane_map_pkg::io_page && addr[11];

    // memory regions never overlap
    memory_select_exclusive: assert property (
        @(posedge clk) disable iff (rst) $onehot0({rom_cs, ram_cs, gfx_cs})
    ) else begin
        $error("more than one of rom_cs, ram_cs and gfx_cs is active");
        assert_errors++;
    end

    io_select_in_page: assert property (
        @(posedge clk) disable iff (rst) (pcm0_cs || pcm1_cs || prot_cs) |-> io_window
    ) else begin
        $error("PCM or protection select active outside the I/O page");
        assert_errors++;
    end

    ack_releases_irq: assert property (
        @(posedge clk) disable iff (rst) irq_ack |=> irq_n
    ) else begin
        $error("irq_n still low one clock after irq_ack");
        assert_errors++;
    end

endmodule

bind flane_bus_decode flane_main_assertions u_assertions (
    .clk     (clk),
    .rst     (rst),
    .addr    (addr),
    .rom_cs  (rom_cs),
    .ram_cs  (ram_cs),
    .gfx_cs  (gfx_cs),
    .pcm0_cs (pcm0_cs),
    .pcm1_cs (pcm1_cs),
    .prot_cs (prot_cs),
    .irq_ack (irq_ack),
    .irq_n   (irq_n)
);

`default_nettype wire

//--- verilog/flane_main.sv
// top level of the main board glue, wires inputs, bus decoder and sound mixer
`default_nettype none

module flane_main #(
    parameter logic [flane_snd_pkg::gain_w-1:0] GAIN0 = 8'h0C,
    parameter logic [flane_snd_pkg::gain_w-1:0] GAIN1 = 8'h0C
) (
    input  wire                                    clk,
    input  wire                                    rst,
    input  wire                                    cpu_cen,
    input  wire                                    snd_cen,
    // CPU bus
    input  wire  [flane_map_pkg::addr_w-1:0]       addr,
    input  wire                                    rnw,
    input  wire                                    vma,
    input  wire  [flane_map_pkg::data_w-1:0]       cpu_dout,
    output logic [flane_map_pkg::data_w-1:0]       cpu_din,
    input  wire                                    irq_ack,
    output logic                                   irq_n,
    // chip selects and returns
    output logic                                   rom_cs,
    output logic                                   ram_cs,
    output logic                                   gfx_cs,
    output logic                                   pcm0_cs,
    output logic                                   pcm1_cs,
    output logic                                   prot_cs,
    output logic [flane_map_pkg::rom_aw-1:0]       rom_addr,
    input  wire  [flane_map_pkg::data_w-1:0]       rom_data,
    input  wire  [flane_map_pkg::data_w-1:0]       ram_dout,
    input  wire  [flane_map_pkg::data_w-1:0]       gfx_dout,
    input  wire  [flane_map_pkg::data_w-1:0]       pal_dout,
    input  wire  [flane_map_pkg::data_w-1:0]       prot_dout,
    input  wire                                    pal_cs,
    input  wire                                    gfx_irqn,
    // cabinet
    input  wire  [1:0]                             start_button,
    input  wire  [1:0]                             coin_input,
    input  wire  [5:0]                             joystick1,
    input  wire  [5:0]                             joystick2,
    input  wire                                    service,
    input  wire                                    dip_pause,
    input  wire  [7:0]                             dipsw_a,
    input  wire  [7:0]                             dipsw_b,
    input  wire  [3:0]                             dipsw_c,
    // sound
    output logic                                   pcm_msb,
    input  wire  signed [flane_snd_pkg::pcm_w-1:0] ch0,
    input  wire  signed [flane_snd_pkg::pcm_w-1:0] ch1,
    output logic signed [flane_snd_pkg::snd_w-1:0] snd,
    output logic                                   peak
);

    logic [flane_map_pkg::data_w-1:0] cabinet;
    logic [flane_map_pkg::data_w-1:0] dips;

    flane_cab_inputs u_inputs (
        .clk          (clk),
        .rst          (rst),
        .addr_lo      (addr[1:0]),
        .start_button (start_button),
        .coin_input   (coin_input),
        .joystick1    (joystick1),
        .joystick2    (joystick2),
        .service      (service),
        .dipsw_a      (dipsw_a),
        .dipsw_b      (dipsw_b),
        .dipsw_c      (dipsw_c),
        .cabinet      (cabinet),
        .dips         (dips)
    );

    flane_bus_decode u_decode (
        .clk       (clk),
        .rst       (rst),
        .cpu_cen   (cpu_cen),
        .addr      (addr),
        .rnw       (rnw),
        .vma       (vma),
        .cpu_dout  (cpu_dout),
        .cabinet   (cabinet),
        .dips      (dips),
        .rom_data  (rom_data),
        .ram_dout  (ram_dout),
        .gfx_dout  (gfx_dout),
        .pal_dout  (pal_dout),
        .prot_dout (prot_dout),
        .pal_cs    (pal_cs),
        .gfx_irqn  (gfx_irqn),
        .dip_pause (dip_pause),
        .irq_ack   (irq_ack),
        .rom_cs    (rom_cs),
        .ram_cs    (ram_cs),
        .gfx_cs    (gfx_cs),
        .pcm0_cs   (pcm0_cs),
        .pcm1_cs   (pcm1_cs),
        .prot_cs   (prot_cs),
        .rom_addr  (rom_addr),
        .pcm_msb   (pcm_msb),
        .cpu_din   (cpu_din),
        .irq_n     (irq_n)
    );

    flane_snd_mixer #(
        .GAIN0 (GAIN0),
        .GAIN1 (GAIN1)
    ) u_mixer (
        .clk     (clk),
        .rst     (rst),
        .snd_cen (snd_cen),
        .ch0     (ch0),
        .ch1     (ch1),
        .snd     (snd),
        .peak    (peak)
    );

endmodule

`default_nettype wire

//--- verilog/flane_snd_mixer.sv
// two channel PCM mixer with fixed 4.4 gains, saturation and a peak flag
`default_nettype none

module flane_snd_mixer #(
    parameter logic [flane_snd_pkg::gain_w-1:0] GAIN0 = 8'h0C,
    parameter logic [flane_snd_pkg::gain_w-1:0] GAIN1 = 8'h0C
) (
    input  wire                                        clk,
    input  wire                                        rst,
    input  wire                                        snd_cen,
    input  wire  signed [flane_snd_pkg::pcm_w-1:0]     ch0,
    input  wire  signed [flane_snd_pkg::pcm_w-1:0]     ch1,
    output logic signed [flane_snd_pkg::snd_w-1:0]     snd,
    output logic                                       peak
);

    localparam int snd_w  = flane_snd_pkg::snd_w;
    localparam int pad_w  = flane_snd_pkg::snd_w - flane_snd_pkg::pcm_w;
    // one extra bit keeps the unsigned gain positive
    localparam int prod_w = snd_w + flane_snd_pkg::gain_w + 1;
    localparam logic signed [snd_w-1:0] snd_max = {1'b0, {(snd_w-1){1'b1}}};
    localparam logic signed [snd_w-1:0] snd_min = {1'b1, {(snd_w-1){1'b0}}};

    logic signed [snd_w-1:0]  wide0;
    logic signed [snd_w-1:0]  wide1;
    logic signed [prod_w-1:0] prod0;
    logic signed [prod_w-1:0] prod1;
    logic signed [prod_w-1:0] scaled0;
    logic signed [prod_w-1:0] scaled1;
    logic signed [prod_w:0]   sum;
    logic                     over;

    // channels become fixed point with zero fraction
    assign wide0 = {ch0, {pad_w{1'b0}}};
    assign wide1 = {ch1, {pad_w{1'b0}}};

    assign prod0 = wide0 * $signed({1'b0, GAIN0});
    assign prod1 = wide1 * $signed({1'b0, GAIN1});

    // drop the gain fraction
    assign scaled0 = prod0 >>> flane_snd_pkg::gain_frac;
    assign scaled1 = prod1 >>> flane_snd_pkg::gain_frac;

    assign sum = scaled0 + scaled1;

    // out of range when the bits above the output sign disagree with it
    assign over = sum[prod_w:snd_w-1] != {(prod_w-snd_w+2){sum[prod_w]}};

    always_ff @(posedge clk) begin
        if (rst) begin
            snd  <= '0;
            peak <= 1'b0;
        end else if (snd_cen) begin
            if (over) begin
                snd <= sum[prod_w] ? snd_min : snd_max;
            end else begin
                snd <= sum[snd_w-1:0];
            end
            peak <= over;
        end
    end

endmodule

`default_nettype wire

//--- verilog/flane_bus_decode.sv
// CPU bus decode with bank register, ROM address, vertical IRQ latch and read mux
`default_nettype none

module flane_bus_decode (
    input  wire                                  clk,
    input  wire                                  rst,
    input  wire                                  cpu_cen,
    input  wire  [flane_map_pkg::addr_w-1:0]     addr,
    input  wire                                  rnw,
    input  wire                                  vma,
    input  wire  [flane_map_pkg::data_w-1:0]     cpu_dout,
    input  wire  [flane_map_pkg::data_w-1:0]     cabinet,
    input  wire  [flane_map_pkg::data_w-1:0]     dips,
    input  wire  [flane_map_pkg::data_w-1:0]     rom_data,
    input  wire  [flane_map_pkg::data_w-1:0]     ram_dout,
    input  wire  [flane_map_pkg::data_w-1:0]     gfx_dout,
    input  wire  [flane_map_pkg::data_w-1:0]     pal_dout,
    input  wire  [flane_map_pkg::data_w-1:0]     prot_dout,
    input  wire                                  pal_cs,
    input  wire                                  gfx_irqn,
    input  wire                                  dip_pause,
    input  wire                                  irq_ack,
    output logic                                 rom_cs,
    output logic                                 ram_cs,
    output logic                                 gfx_cs,
    output logic                                 pcm0_cs,
    output logic                                 pcm1_cs,
    output logic                                 prot_cs,
    output logic [flane_map_pkg::rom_aw-1:0]     rom_addr,
    output logic                                 pcm_msb,
    output logic [flane_map_pkg::data_w-1:0]     cpu_din,
    output logic                                 irq_n
);

    logic [flane_map_pkg::page_w-1:0]   page;
    logic [flane_map_pkg::io_sel_w-1:0] io_sel;
    logic                               io_cs;
    logic                               in_cs;
    logic                               sys_cs;
    logic                               bank_cs;
    logic [flane_map_pkg::bank_w-1:0]   bank;
    logic                               irq_trig;
    logic                               irq_trig_l;

    assign page   = addr[flane_map_pkg::addr_w-1 -: flane_map_pkg::page_w];
    assign io_sel = addr[10:8];

    // pages 0 and 1 only hold I/O and RAM in their upper half
    assign io_cs  = page == flane_map_pkg::io_page && addr[11];
    assign ram_cs = page == flane_map_pkg::ram_page && addr[11];
    assign rom_cs = page >= flane_map_pkg::rom_first_page && rnw && vma;
    assign gfx_cs = page < flane_map_pkg::rom_first_page && !io_cs && !ram_cs;

    assign in_cs   = io_cs && io_sel == flane_map_pkg::io_inputs && rnw;
    assign sys_cs  = io_cs && io_sel == flane_map_pkg::io_dips && rnw;
    assign bank_cs = io_cs && io_sel == flane_map_pkg::io_bank && !rnw;
    assign pcm0_cs = io_cs && io_sel == flane_map_pkg::io_pcm0;
    assign pcm1_cs = io_cs && io_sel == flane_map_pkg::io_pcm1;
    assign prot_cs = io_cs && io_sel == flane_map_pkg::io_prot;

    // upper 32k is fixed, lower half maps a 16k bank window
    assign rom_addr = addr[flane_map_pkg::addr_w-1]
                    ? {2'b00, addr[14:0]}
                    : flane_map_pkg::bank_base + {1'b0, bank, addr[13:0]};

    always_ff @(posedge clk) begin
        if (rst) begin
            bank    <= '0;
            pcm_msb <= 1'b0;
        end else if (cpu_cen && bank_cs) begin
            bank    <= cpu_dout[3:2];
            pcm_msb <= cpu_dout[4];
        end
    end

    // vertical interrupt, gated by the pause DIP
    assign irq_trig = ~gfx_irqn & dip_pause;

    always_ff @(posedge clk) begin
        if (rst) begin
            irq_trig_l <= 1'b0;
            irq_n      <= 1'b1;
        end else begin
            irq_trig_l <= irq_trig;
            // ack wins over a new edge
            if (irq_ack) begin
                irq_n <= 1'b1;
            end else if (irq_trig && !irq_trig_l) begin
                irq_n <= 1'b0;
            end
        end
    end

    // palette sits inside the gfx range and takes precedence
    always_ff @(posedge clk) begin
        if (rst) begin
            cpu_din <= flane_map_pkg::open_bus;
        end else if (rom_cs) begin
            cpu_din <= rom_data;
        end else if (ram_cs) begin
            cpu_din <= ram_dout;
        end else if (pal_cs) begin
            cpu_din <= pal_dout;
        end else if (gfx_cs) begin
            cpu_din <= gfx_dout;
        end else if (in_cs) begin
            cpu_din <= cabinet;
        end else if (sys_cs) begin
            cpu_din <= dips;
        end else if (prot_cs) begin
            cpu_din <= prot_dout;
        end else begin
            cpu_din <= flane_map_pkg::open_bus;
        end
    end

endmodule

`default_nettype wire

//--- verilog/flane_cab_inputs.sv
// samples cabinet controls and DIP switches and formats the bytes the CPU reads
`default_nettype none

module flane_cab_inputs (
    input  wire        clk,
    input  wire        rst,
    input  wire  [1:0] addr_lo,
    input  wire  [1:0] start_button,
    input  wire  [1:0] coin_input,
    input  wire  [5:0] joystick1,
    input  wire  [5:0] joystick2,
    input  wire        service,
    input  wire  [7:0] dipsw_a,
    input  wire  [7:0] dipsw_b,
    input  wire  [3:0] dipsw_c,
    output logic [flane_map_pkg::data_w-1:0] cabinet,
    output logic [flane_map_pkg::data_w-1:0] dips
);

    logic [1:0] start_r;
    logic [1:0] coin_r;
    logic [5:0] joy1_r;
    logic [5:0] joy2_r;
    logic       service_r;
    logic [7:0] dipa_r;
    logic [7:0] dipb_r;
    logic [3:0] dipc_r;

    // controls are active low, reset shows everything released
    always_ff @(posedge clk) begin
        if (rst) begin
            start_r   <= '1;
            coin_r    <= '1;
            joy1_r    <= '1;
            joy2_r    <= '1;
            service_r <= 1'b1;
            dipa_r    <= '1;
            dipb_r    <= '1;
            dipc_r    <= '1;
        end else begin
            start_r   <= start_button;
            coin_r    <= coin_input;
            joy1_r    <= joystick1;
            joy2_r    <= joystick2;
            service_r <= service;
            dipa_r    <= dipsw_a;
            dipb_r    <= dipsw_b;
            dipc_r    <= dipsw_c;
        end
    end

    // directions swapped in pairs to match the board wiring
    always_comb begin
        case (addr_lo)
            2'd0: cabinet = {4'hf, dipc_r};
            2'd1: cabinet = {2'b11, joy2_r[5:4], joy2_r[2], joy2_r[3], joy2_r[0], joy2_r[1]};
            2'd2: cabinet = {2'b11, joy1_r[5:4], joy1_r[2], joy1_r[3], joy1_r[0], joy1_r[1]};
            default: cabinet = {3'b111, start_r, service_r, coin_r};
        endcase
    end

    assign dips = addr_lo[0] ? dipb_r : dipa_r;

endmodule

`default_nettype wire

//--- verilog/flane_snd_pkg.sv
// sample widths and gain format for the PCM mixer and the top level
`default_nettype none

package flane_snd_pkg;

    // raw PCM channel from each sound chip, signed
    localparam int pcm_w = 12;

    // mixed output, signed
    localparam int snd_w = 16;

    // gain is unsigned 4.4 fixed point
    localparam int gain_w    = 8;
    localparam int gain_frac = 4;

endpackage

`default_nettype wire

//--- verilog/flane_map_pkg.sv
// memory map, page and I/O select codes and bus widths for the CPU side decode
`default_nettype none

package flane_map_pkg;

    // CPU bus
    localparam int addr_w = 16;
    localparam int data_w = 8;

    // external ROM address and bank register
    localparam int rom_aw = 17;
    localparam int bank_w = 2;

    // page number is the top address nibble
    localparam int page_w = 4;
    localparam logic [page_w-1:0] io_page        = 4'd0;
    localparam logic [page_w-1:0] ram_page       = 4'd1;
    localparam logic [page_w-1:0] rom_first_page = 4'd4;

    // I/O select field, address bits 10 to 8
    localparam int io_sel_w = 3;
    localparam logic [io_sel_w-1:0] io_inputs = 3'd0;
    localparam logic [io_sel_w-1:0] io_dips   = 3'd1;
    localparam logic [io_sel_w-1:0] io_bank   = 3'd4;
    localparam logic [io_sel_w-1:0] io_pcm0   = 3'd5;
    localparam logic [io_sel_w-1:0] io_pcm1   = 3'd6;
    localparam logic [io_sel_w-1:0] io_prot   = 3'd7;

    // banked window lands above the fixed ROM half
    localparam logic [rom_aw-1:0] bank_base = 17'h08000;

    // nothing selected
    localparam logic [data_w-1:0] open_bus = 8'hff;

endpackage

`default_nettype wire
